/* hdl/cross_unit.sv */
`timescale 1ns/1ps

module cross_unit #(
    parameter int Q_BITS = vec_pkg::q_bits_default
) (
    input  logic              clock,
    input  logic              reset,
    input  vec_pkg::vec3_t    a,
    input  vec_pkg::vec3_t    b,
    input  logic              in_empty,
    output logic              in_rd_en,
    output vec_pkg::vec_res_u result,
    input  logic              out_full,
    output logic              out_wr_en
);

    typedef enum logic {
        s0,
        s1
    } state_e;

    state_e             state;
    state_e             next_state;
    logic signed [63:0] p12;
    logic signed [63:0] p21;
    logic signed [63:0] p20;
    logic signed [63:0] p02;
    logic signed [63:0] p01;
    logic signed [63:0] p10;
    logic signed [63:0] diff0;
    logic signed [63:0] diff1;
    logic signed [63:0] diff2;
    vec_pkg::vec_res_u  result_next;

    // ~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // scaled products.
        p12 = ($signed(a.e1) * $signed(b.e2)) >>> Q_BITS;
        p21 = ($signed(a.e2) * $signed(b.e1)) >>> Q_BITS;
        p20 = ($signed(a.e2) * $signed(b.e0)) >>> Q_BITS;
        p02 = ($signed(a.e0) * $signed(b.e2)) >>> Q_BITS;
        p01 = ($signed(a.e0) * $signed(b.e1)) >>> Q_BITS;
        p10 = ($signed(a.e1) * $signed(b.e0)) >>> Q_BITS;

        diff0 = p12 - p21;
        diff1 = p20 - p02;
        diff2 = p01 - p10;

        // truncate each element to 32 bits.
        result_next.vector.e0 = diff0[31:0];
        result_next.vector.e1 = diff1[31:0];
        result_next.vector.e2 = diff2[31:0];
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            result <= result_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        case (state)
            s0: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    next_state = s1;
                end
            end
            s1: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = s0;
                end
            end
            default: next_state = s0;
        endcase
    end

endmodule

/* hdl/dot_unit.sv */
`timescale 1ns/1ps

module dot_unit #(
    parameter int Q_BITS = vec_pkg::q_bits_default
) (
    input  logic              clock,
    input  logic              reset,
    input  vec_pkg::vec3_t    a,
    input  vec_pkg::vec3_t    b,
    input  logic              in_empty,
    output logic              in_rd_en,
    output vec_pkg::vec_res_u result,
    input  logic              out_full,
    output logic              out_wr_en
);

    typedef enum logic {
        s0,
        s1
    } state_e;

    state_e             state;
    state_e             next_state;
    logic signed [63:0] prod0;
    logic signed [63:0] prod1;
    logic signed [63:0] prod2;
    logic signed [63:0] term0;
    logic signed [63:0] term1;
    logic signed [63:0] term2;
    logic signed [63:0] sum;
    vec_pkg::vec_res_u  result_next;

    // ~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        prod0 = $signed(a.e0) * $signed(b.e0);
        prod1 = $signed(a.e1) * $signed(b.e1);
        prod2 = $signed(a.e2) * $signed(b.e2);

        // back to Q format before the sum.
        term0 = prod0 >>> Q_BITS;
        term1 = prod1 >>> Q_BITS;
        term2 = prod2 >>> Q_BITS;

        sum = term0 + term1 + term2;

        result_next.scalar.pad   = '0;
        result_next.scalar.value = sum[31:0];
    end

    // result is captured with the pop.
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            result <= result_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        case (state)
            s0: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    next_state = s1;
                end
            end
            s1: begin
                // hold until the result FIFO has room.
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = s0;
                end
            end
            default: next_state = s0;
        endcase
    end

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int ADDR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [ADDR_BITS-1:0]  wr_ptr;
    logic [ADDR_BITS-1:0]  rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_write;
    logic                  do_read;

    // pointer step with wrap, depth need not be a power of two.
    function automatic logic [ADDR_BITS-1:0] next_ptr(input logic [ADDR_BITS-1:0] ptr);
        logic [ADDR_BITS-1:0] nxt;
        if (ptr == ADDR_BITS'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // flags and head
    // ~~~~~~~~~~~~~~~~~~~~

    assign full  = (count == COUNT_BITS'(DEPTH));
    assign empty = (count == '0);

    // overflow and underflow are dropped.
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // show-ahead.
    assign dout = mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/vec_dispatch.sv */
`timescale 1ns/1ps

module vec_dispatch (
    input  logic              clock,
    input  logic              reset,

    // command side.
    input  vec_pkg::vec_cmd_t head,
    input  logic              cmd_empty,
    output logic              cmd_rd_en,

    // unit read side.
    output logic              dot_empty,
    output logic              cross_empty,
    input  logic              dot_rd_en,
    input  logic              cross_rd_en,

    // unit write side.
    input  logic              dot_wr_en,
    input  logic              cross_wr_en,
    input  vec_pkg::vec_res_u dot_result,
    input  vec_pkg::vec_res_u cross_result,

    // result side.
    output vec_pkg::vec_res_t res,
    output logic              res_wr_en
);

    logic busy;
    logic head_is_dot;
    logic head_is_cross;
    logic head_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // command steering
    // ~~~~~~~~~~~~~~~~~~~~

    assign head_is_dot   = (head.op == vec_pkg::op_dot);
    assign head_is_cross = (head.op == vec_pkg::op_cross);

    // a head is offered only while no command is in flight.
    assign head_ready = !cmd_empty && !busy;

    assign dot_empty   = !(head_ready && head_is_dot);
    assign cross_empty = !(head_ready && head_is_cross);

    // at most one unit sees the head, so at most one pops.
    assign cmd_rd_en = dot_rd_en || cross_rd_en;

    // ~~~~~~~~~~~~~~~~~~~~
    // result merge
    // ~~~~~~~~~~~~~~~~~~~~

    assign res_wr_en = dot_wr_en || cross_wr_en;

    always_comb begin
        if (cross_wr_en) begin
            res.op    = vec_pkg::op_cross;
            res.value = cross_result;
        end else begin
            res.op    = vec_pkg::op_dot;
            res.value = dot_result;
        end
    end

    // set on pop, clear on result write.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (cmd_rd_en) begin
            busy <= 1'b1;
        end else if (res_wr_en) begin
            busy <= 1'b0;
        end
    end

endmodule

/* hdl/vec_pkg.sv */
package vec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // fixed-point format
    // ~~~~~~~~~~~~~~~~~~~~

    // fraction bits of the Q format.
    localparam int q_bits_default = 10;

    // ~~~~~~~~~~~~~~~~~~~~
    // operations
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        op_dot   = 1'b0,
        op_cross = 1'b1
    } vec_op_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // data words
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic signed [31:0] e0;
        logic signed [31:0] e1;
        logic signed [31:0] e2;
    } vec3_t;

    // one command word.
    typedef struct packed {
        vec_op_e op;
        vec3_t   a;
        vec3_t   b;
    } vec_cmd_t;

    // scalar result sits in the low word.
    typedef struct packed {
        logic [63:0]        pad;
        logic signed [31:0] value;
    } vec_scalar_t;

    typedef union packed {
        vec3_t       vector;
        vec_scalar_t scalar;
    } vec_res_u;

    // op tells the reader which view of value to use.
    typedef struct packed {
        vec_op_e  op;
        vec_res_u value;
    } vec_res_t;

endpackage

/* hdl/vec_top.sv */
`timescale 1ns/1ps

module vec_top #(
    parameter int Q_BITS    = vec_pkg::q_bits_default,
    parameter int CMD_DEPTH = 4,
    parameter int RES_DEPTH = 4
) (
    input  logic              clock,
    input  logic              reset,
    input  vec_pkg::vec_cmd_t cmd,
    input  logic              cmd_wr_en,
    output logic              cmd_full,
    output vec_pkg::vec_res_t res,
    input  logic              res_rd_en,
    output logic              res_empty
);

    vec_pkg::vec_cmd_t cmd_head;
    logic              cmd_empty;
    logic              cmd_rd_en;

    logic              dot_empty;
    logic              dot_rd_en;
    logic              dot_wr_en;
    vec_pkg::vec_res_u dot_result;

    logic              cross_empty;
    logic              cross_rd_en;
    logic              cross_wr_en;
    vec_pkg::vec_res_u cross_result;

    vec_pkg::vec_res_t res_in;
    logic              res_wr_en;
    logic              res_full;

    sync_fifo #(
        .WIDTH ($bits(vec_pkg::vec_cmd_t)),
        .DEPTH (CMD_DEPTH)
    ) i_cmd_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (cmd_wr_en),
        .din   (cmd),
        .full  (cmd_full),
        .rd_en (cmd_rd_en),
        .dout  (cmd_head),
        .empty (cmd_empty)
    );

    vec_dispatch i_dispatch (
        .clock        (clock),
        .reset        (reset),
        .head         (cmd_head),
        .cmd_empty    (cmd_empty),
        .cmd_rd_en    (cmd_rd_en),
        .dot_empty    (dot_empty),
        .cross_empty  (cross_empty),
        .dot_rd_en    (dot_rd_en),
        .cross_rd_en  (cross_rd_en),
        .dot_wr_en    (dot_wr_en),
        .cross_wr_en  (cross_wr_en),
        .dot_result   (dot_result),
        .cross_result (cross_result),
        .res          (res_in),
        .res_wr_en    (res_wr_en)
    );

    // both units share the result FIFO full flag.
    dot_unit #(
        .Q_BITS (Q_BITS)
    ) i_dot_unit (
        .clock     (clock),
        .reset     (reset),
        .a         (cmd_head.a),
        .b         (cmd_head.b),
        .in_empty  (dot_empty),
        .in_rd_en  (dot_rd_en),
        .result    (dot_result),
        .out_full  (res_full),
        .out_wr_en (dot_wr_en)
    );

    cross_unit #(
        .Q_BITS (Q_BITS)
    ) i_cross_unit (
        .clock     (clock),
        .reset     (reset),
        .a         (cmd_head.a),
        .b         (cmd_head.b),
        .in_empty  (cross_empty),
        .in_rd_en  (cross_rd_en),
        .result    (cross_result),
        .out_full  (res_full),
        .out_wr_en (cross_wr_en)
    );

    sync_fifo #(
        .WIDTH ($bits(vec_pkg::vec_res_t)),
        .DEPTH (RES_DEPTH)
    ) i_res_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_in),
        .full  (res_full),
        .rd_en (res_rd_en),
        .dout  (res),
        .empty (res_empty)
    );

endmodule

/* list.f */
+incdir+verification
hdl/vec_pkg.sv
hdl/sync_fifo.sv
hdl/dot_unit.sv
hdl/cross_unit.sv
hdl/vec_dispatch.sv
hdl/vec_top.sv
verification/vec_tb.sv

/* run.sh */
#!/bin/sh
# build and run the vector unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module vec_tb \
        -Mdir obj_dir -f list.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vvec_tb > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$log"

if grep -q "Simulation finished: PASS" "$log"; then
    exit 0
fi

echo "pass line not found in $log"
exit 1

/* verification/vec_model.svh */
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

// one product in Q format, floor shift of the full 64-bit product.
function automatic longint scaled_product(input logic signed [31:0] x,
                                          input logic signed [31:0] y,
                                          input int q);
    longint p;
    p = longint'(x) * longint'(y);
    return p >>> q;
endfunction

function automatic logic signed [31:0] model_dot(input vec_pkg::vec3_t a,
                                                 input vec_pkg::vec3_t b,
                                                 input int q);
    longint s;
    s = scaled_product(a.e0, b.e0, q) + scaled_product(a.e1, b.e1, q)
        + scaled_product(a.e2, b.e2, q);
    // sum wraps at 32 bits.
    return 32'(s);
endfunction

function automatic vec_pkg::vec3_t model_cross(input vec_pkg::vec3_t a,
                                               input vec_pkg::vec3_t b,
                                               input int q);
    vec_pkg::vec3_t r;
    r.e0 = 32'(scaled_product(a.e1, b.e2, q) - scaled_product(a.e2, b.e1, q));
    r.e1 = 32'(scaled_product(a.e2, b.e0, q) - scaled_product(a.e0, b.e2, q));
    r.e2 = 32'(scaled_product(a.e0, b.e1, q) - scaled_product(a.e1, b.e0, q));
    return r;
endfunction

// tagged result word as the host reads it.
function automatic vec_pkg::vec_res_t expected_result(input vec_pkg::vec_cmd_t c,
                                                      input int q);
    vec_pkg::vec_res_t r;
    r.op = c.op;
    if (c.op == vec_pkg::op_dot) begin
        r.value.scalar.pad   = '0;
        r.value.scalar.value = model_dot(c.a, c.b, q);
    end else begin
        r.value.vector = model_cross(c.a, c.b, q);
    end
    return r;
endfunction

`endif

/* verification/vec_tb.sv */
`timescale 1ns/1ps

module vec_tb;

    localparam int q_bits    = 10;
    localparam int cmd_depth = 4;
    localparam int res_depth = 4;
    localparam int n_dot     = 400;
    localparam int n_cross   = 400;
    localparam int n_mix     = 200;
    // about twice the whole run at two cycles per command.
    localparam int timeout_cycles = 4000;

    logic              clock;
    logic              reset;
    vec_pkg::vec_cmd_t cmd;
    logic              cmd_wr_en;
    logic              cmd_full;
    vec_pkg::vec_res_t res;
    logic              res_rd_en = 1'b0;
    logic              res_empty;

    vec_pkg::vec_res_t exp_q[$];
    vec_pkg::vec_res_t chk_exp;
    vec_pkg::vec_res_t chk_act;
    logic              chk_valid = 1'b0;
    logic              read_on;
    logic              wrote_any;
    int                pop_count = 0;
    int                accepted_total = 0;
    int                cycle_count = 0;
    string             test_name = "reset_state";

    `include "vec_model.svh"

    vec_top #(
        .Q_BITS    (q_bits),
        .CMD_DEPTH (cmd_depth),
        .RES_DEPTH (res_depth)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_wr_en (cmd_wr_en),
        .cmd_full  (cmd_full),
        .res       (res),
        .res_rd_en (res_rd_en),
        .res_empty (res_empty)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic vec_pkg::vec3_t make_vec(input int x, input int y, input int z);
        vec_pkg::vec3_t v;
        v.e0 = x;
        v.e1 = y;
        v.e2 = z;
        return v;
    endfunction

    function automatic vec_pkg::vec_cmd_t make_cmd(input vec_pkg::vec_op_e op,
                                                   input vec_pkg::vec3_t a,
                                                   input vec_pkg::vec3_t b);
        vec_pkg::vec_cmd_t c;
        c.op = op;
        c.a  = a;
        c.b  = b;
        return c;
    endfunction

    // mostly about +-512.0 in Q10, sometimes full range to force wrap.
    function automatic logic signed [31:0] random_elem();
        logic signed [31:0] v;
        if ($urandom_range(0, 3) == 0) begin
            v = $urandom;
        end else begin
            v = $signed($urandom_range(0, 1048575)) - 32'sd524288;
        end
        return v;
    endfunction

    function automatic vec_pkg::vec_cmd_t random_cmd(input vec_pkg::vec_op_e op);
        vec_pkg::vec_cmd_t c;
        c.op   = op;
        c.a.e0 = random_elem();
        c.a.e1 = random_elem();
        c.a.e2 = random_elem();
        c.b.e0 = random_elem();
        c.b.e1 = random_elem();
        c.b.e2 = random_elem();
        return c;
    endfunction

    function automatic vec_pkg::vec_op_e random_op();
        return vec_pkg::vec_op_e'($urandom_range(0, 1));
    endfunction

    function automatic void record_accept(input vec_pkg::vec_cmd_t c);
        exp_q.push_back(expected_result(c, q_bits));
        accepted_total++;
    endfunction

    // holds the command until the FIFO takes it.
    task automatic send_cmd(input vec_pkg::vec_cmd_t c);
        cmd       <= c;
        cmd_wr_en <= 1'b1;
        wrote_any <= 1'b1;
        @(posedge clock);
        while (cmd_full) begin
            @(posedge clock);
        end
        record_accept(c);
    endtask

    task automatic drain();
        cmd_wr_en <= 1'b0;
        while (exp_q.size() != 0 || !res_empty) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // result reader and checks
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin
        res_rd_en <= read_on && !res_empty;
    end

    always @(posedge clock) begin
        chk_valid <= 1'b0;
        if (!reset && res_rd_en && !res_empty) begin
            if (exp_q.size() == 0) begin
                fail_run("a result came out with no command waiting for it");
            end else begin
                chk_valid <= 1'b1;
                chk_exp   <= exp_q.pop_front();
                chk_act   <= res;
                pop_count <= pop_count + 1;
            end
        end
    end

    result_matches: assert property (@(posedge clock) disable iff (reset)
        chk_valid |-> (chk_act == chk_exp))
        else fail_run($sformatf("CHECK FAILED %s expected %h actual %h", test_name,
                                $sampled(chk_exp), $sampled(chk_act)));

    reset_state: assert property (@(posedge clock) disable iff (reset)
        !wrote_any |-> (res_empty && !cmd_full))
        else fail_run($sformatf({"CHECK FAILED reset_state expected res_empty=1 cmd_full=0",
                                 " actual res_empty=%0b cmd_full=%0b"},
                                $sampled(res_empty), $sampled(cmd_full)));

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                               timeout_cycles));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        vec_pkg::vec_cmd_t c;
        int                accepted;
        int                full_run;
        int                pops_before;

        void'($urandom(89570));
        reset     = 1'b1;
        cmd       = '0;
        cmd_wr_en = 1'b0;
        read_on   = 1'b0;
        wrote_any = 1'b0;
        repeat (3) @(posedge clock);
        reset   <= 1'b0;
        read_on <= 1'b1;
        repeat (4) @(posedge clock);

        test_name = "dot_fixed";
        send_cmd(make_cmd(vec_pkg::op_dot, make_vec(1024, 2048, 3072),
                          make_vec(4096, -5120, 6144)));
        send_cmd(make_cmd(vec_pkg::op_dot, make_vec(0, 0, 0), make_vec(777, -3, 9)));
        send_cmd(make_cmd(vec_pkg::op_dot, make_vec(-1536, 256, -3072),
                          make_vec(2048, -8192, 512)));
        // small negative products, floor shift.
        send_cmd(make_cmd(vec_pkg::op_dot, make_vec(-1, 1, -3), make_vec(1, 1, 1)));
        send_cmd(make_cmd(vec_pkg::op_dot, make_vec(2147483647, -2147483648, 2147483647),
                          make_vec(2147483647, -2147483648, -2147483648)));
        drain();

        test_name = "dot_random";
        for (int i = 0; i < n_dot; i++) begin
            send_cmd(random_cmd(vec_pkg::op_dot));
        end
        drain();

        test_name = "cross_random";
        for (int i = 0; i < n_cross; i++) begin
            send_cmd(random_cmd(vec_pkg::op_cross));
        end
        drain();

        test_name = "ordering";
        for (int i = 0; i < n_mix; i++) begin
            send_cmd(random_cmd(random_op()));
        end
        drain();

        test_name = "backpressure";
        read_on <= 1'b0;
        repeat (2) @(posedge clock);
        accepted = 0;
        full_run = 0;
        c = random_cmd(random_op());
        cmd       <= c;
        cmd_wr_en <= 1'b1;
        // keep offering until cmd_full has stayed high for a while.
        while (full_run < 16) begin
            @(posedge clock);
            if (!cmd_full) begin
                record_accept(c);
                accepted++;
                full_run = 0;
                c = random_cmd(random_op());
                cmd <= c;
            end else begin
                full_run++;
            end
        end
        cmd_wr_en <= 1'b0;
        bp_depth: assert (accepted <= cmd_depth + res_depth + 1)
            else fail_run($sformatf("CHECK FAILED backpressure expected at most %0d actual %0d",
                                    cmd_depth + res_depth + 1, accepted));
        pops_before = pop_count;
        read_on <= 1'b1;
        while (pop_count - pops_before < accepted) begin
            @(posedge clock);
        end
        repeat (6) @(posedge clock);
        bp_drain: assert (exp_q.size() == 0 && res_empty)
            else fail_run($sformatf("CHECK FAILED backpressure expected 0 left actual %0d",
                                    exp_q.size()));

        if (pop_count == accepted_total && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run($sformatf("%0d commands accepted but %0d results read",
                               accepted_total, pop_count));
        end
    end

endmodule
